// File: sim.f
+incdir+source
source/isaPkg.sv
source/linkPkg.sv
source/instQueue.sv
source/interruptLatch.sv
source/instDecode.sv
source/frontEnd.sv
bench/clockGen.sv
bench/frontEndChecker.sv
bench/frontEndTb.sv

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert \
  -f sim.f \
  --top-module frontEndTb \
  -Mdir obj_dir \
  -o frontEndSim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/frontEndSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// File: bench/frontEndTb.sv
`timescale 1ns/10ps
`include "ibuf_params.svh"

module frontEndTb;

  import isaPkg::*;
  import linkPkg::*;

  localparam int QueueDepth = `IBUF_QUEUE_DEPTH;
  localparam int OutCredits = `IBUF_OUT_CREDITS;
  localparam int WaitLimit  = 300;

  logic        gclk;
  logic        rstN;
  fetchLinkT   fetchIn;
  logic        fetchCredit;
  logic        intRequest;
  logic        intEnable;
  decodeLinkT  decodeOut;
  logic        decodeCredit;

  logic [31:0] lfsrState = 32'h9423805b;
  logic [31:0] expectQ[$];
  int          creditQ[$];
  int          fetchCredits = QueueDepth;
  int          outCount = 0;
  int          intCount = 0;
  int          expectedInts = 0;
  logic        holdCredits = 1'b0;
  logic [5:0]  prevWordOpc = '0;
  logic [15:0] prevWordLow = '0;
  logic [5:0]  lastOutOpc = '0;

  clockGen u_clockGen (
    .gclk (gclk),
    .rstN (rstN)
  );

  frontEnd u_frontEnd (
    .gclk         (gclk),
    .rstN         (rstN),
    .fetchIn      (fetchIn),
    .fetchCredit  (fetchCredit),
    .intRequest   (intRequest),
    .intEnable    (intEnable),
    .decodeOut    (decodeOut),
    .decodeCredit (decodeCredit)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned randBits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = (v << 1) | int'(lfsrState[0]);
    end
    return v;
  endfunction

  // Prefix, return and the four branches
  function automatic logic ownsNextSlot(input logic [5:0] opc);
    return opc inside {6'o46, 6'o47, 6'o54, 6'o55, 6'o56, 6'o57};
  endfunction

  function automatic logic [31:0] makeWord(input bit plainOnly);
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] low;
    logic        b;
    logic        c;
    int unsigned sel;
    sel = plainOnly ? 7 : randBits(3);
    b = 1'(randBits(1));
    c = 1'(randBits(1));
    case (sel)
      0: opc = 6'o54;
      1: opc = 6'o55;
      2, 3: opc = {2'b10, b, 2'b11, c};
      // Codes below octal 40 are never special
      default: opc = {1'b0, 5'(randBits(5))};
    endcase
    rd = 5'(randBits(5));
    ra = 5'(randBits(5));
    low = 16'(randBits(16));
    return {opc, rd, ra, low};
  endfunction

  function automatic decodedOpT refDecode(input logic [31:0] word,
                                          input logic [5:0] prevOpc,
                                          input logic [15:0] prefix);
    decodedOpT r;
    r.opcode = opcodeT'(word[31:26]);
    r.rd = word[25:21];
    r.ra = word[20:16];
    r.rb = word[15:11];
    if (prevOpc == 6'o54) begin
      r.imm = {prefix, word[15:0]};
    end else begin
      r.imm = {{16{word[15]}}, word[15:0]};
    end
    r.isInterrupt = 1'b0;
    return r;
  endfunction

  function automatic decodedOpT interruptOp();
    decodedOpT   r;
    logic [15:0] low;
    low = `IBUF_INT_IMM;
    r.opcode = opcodeT'(`IBUF_INT_OPCODE);
    r.rd = `IBUF_INT_RD;
    r.ra = `IBUF_INT_RA;
    r.rb = low[15:11];
    r.imm = {{16{low[15]}}, low};
    r.isInterrupt = 1'b1;
    return r;
  endfunction

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("Fail at %t: %s, got %h expected %h", $realtime, what, got, exp));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge gclk);
      #1;
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic sendWord(input logic [31:0] word);
    int waited;
    waited = 0;
    while (fetchCredits == 0) begin
      fetchIn.valid = 1'b0;
      idle(1);
      waited++;
      if (waited > WaitLimit) abortRun("Sender waited too long for a fetch credit");
    end
    fetchIn = '{valid: 1'b1, word: word};
    fetchCredits--;
    expectQ.push_back(word);
    idle(1);
    fetchIn.valid = 1'b0;
  endtask

  task automatic waitDrained();
    int waited;
    waited = 0;
    @(negedge gclk);
    #1;
    while (expectQ.size() != 0 || creditQ.size() != 0) begin
      @(negedge gclk);
      #1;
      waited++;
      if (waited > WaitLimit) abortRun("Words or output credits never drained");
    end
    idle(1);
  endtask

  task automatic waitIntCount(input int target);
    int waited;
    waited = 0;
    while (intCount != target) begin
      @(negedge gclk);
      #1;
      waited++;
      if (waited > WaitLimit) abortRun("Interrupt operation never appeared");
    end
    idle(1);
  endtask

  task automatic pulseRequest();
    intRequest = 1'b1;
    idle(2);
    intRequest = 1'b0;
    idle(6);
  endtask

  always @(negedge gclk) begin : compareOutputs
    decodedOpT   expOp;
    logic [31:0] word;
    if (rstN) begin
      if (fetchCredit) begin
        fetchCredits++;
        checkValue("fetch credits within depth", 64'(fetchCredits <= QueueDepth), 64'd1);
      end
      if (decodeOut.valid) begin
        outCount++;
        creditQ.push_back(int'(randBits(2)));
        if (decodeOut.op.isInterrupt) begin
          intCount++;
          checkValue("interrupt operation", {10'd0, decodeOut.op}, {10'd0, interruptOp()});
          checkValue("interrupt after IMM, return or branch",
                     64'(ownsNextSlot(lastOutOpc)), 64'd0);
        end else if (expectQ.size() == 0) begin
          abortRun("A decoded operation appeared with no word outstanding");
        end else begin
          word = expectQ.pop_front();
          expOp = refDecode(word, prevWordOpc, prevWordLow);
          checkValue("decoded operation", {10'd0, decodeOut.op}, {10'd0, expOp});
          prevWordOpc = word[31:26];
          prevWordLow = word[15:0];
        end
        lastOutOpc = decodeOut.op.opcode;
      end
    end
  end

  // Returns one credit per output after a short random delay
  initial begin : creditReturn
    decodeCredit = 1'b0;
    forever begin
      @(posedge gclk);
      #1;
      decodeCredit = 1'b0;
      if (rstN && !holdCredits && creditQ.size() > 0) begin
        if (creditQ[0] == 0) begin
          decodeCredit = 1'b1;
          void'(creditQ.pop_front());
        end else begin
          creditQ[0] = creditQ[0] - 1;
        end
      end
    end
  end

  initial begin : stimulus
    int waited;
    int startCount;
    fetchIn = '0;
    intRequest = 1'b0;
    intEnable = 1'b0;
    waited = 0;
    $timeformat(-9, 1, " ns", 0);
    while (rstN !== 1'b1) begin
      @(negedge gclk);
      waited++;
      if (waited > WaitLimit) abortRun("Reset was never released");
    end

    // Quiet outputs before any stimulus
    repeat (5) begin
      @(negedge gclk);
      checkValue("decodeOut valid after reset", 64'(decodeOut.valid), 64'd0);
      checkValue("fetchCredit after reset", 64'(fetchCredit), 64'd0);
    end
    idle(1);

    // Random mix with gaps and random credit returns
    intEnable = 1'b1;
    repeat (48) begin
      sendWord(makeWord(1'b0));
      idle(int'(randBits(2)));
    end
    waitDrained();

    // Withhold output credits until the queue backs up
    @(negedge gclk);
    holdCredits = 1'b1;
    idle(1);
    startCount = outCount;
    repeat (QueueDepth + OutCredits) sendWord(makeWord(1'b0));
    idle(20);
    checkValue("operations without returned credits",
               64'((outCount - startCount) <= OutCredits), 64'd1);
    checkValue("fetch credits with a full queue", 64'(fetchCredits), 64'd0);
    @(negedge gclk);
    holdCredits = 1'b0;
    idle(1);
    waitDrained();

    // A plain word after each pulse frees a slot held by a branch
    repeat (6) begin
      sendWord(makeWord(1'b0));
      pulseRequest();
      expectedInts++;
      sendWord(makeWord(1'b1));
      waitIntCount(expectedInts);
      idle(4);
    end
    waitDrained();

    // Masked pulses
    intEnable = 1'b0;
    repeat (3) begin
      pulseRequest();
      sendWord(makeWord(1'b1));
    end
    waitDrained();
    intEnable = 1'b1;
    idle(10);
    checkValue("interrupt operation count", 64'(intCount), 64'(expectedInts));
    checkValue("fetch credits after drain", 64'(fetchCredits), 64'(QueueDepth));

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: bench/frontEndChecker.sv
`timescale 1ns/10ps
`include "ibuf_params.svh"

module frontEndChecker (
  input logic                gclk,
  input logic                rstN,
  input linkPkg::decodeLinkT decodeOut,
  input logic                decodeCredit,
  input logic                pop,
  input logic                notEmpty,
  input logic                intTaken
);

  localparam int OutCredits = `IBUF_OUT_CREDITS;

  // Operations out on the link and not yet paid back by the consumer
  int outstanding;

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(decodeOut.valid) - int'(decodeCredit);
    end
  end

  creditFloor: assert property (@(posedge gclk) disable iff (!rstN)
    (outstanding >= 0) && (outstanding <= OutCredits))
    else $error("Decode issued more operations than it held credits for");

  intTakenMatch: assert property (@(posedge gclk) disable iff (!rstN)
    intTaken == (decodeOut.valid && decodeOut.op.isInterrupt))
    else $error("intTaken does not line up with an interrupt operation");

  popNeedsWord: assert property (@(posedge gclk) disable iff (!rstN)
    pop |-> notEmpty)
    else $error("Queue popped while empty");

endmodule

bind frontEnd frontEndChecker u_checker (
  .gclk         (gclk),
  .rstN         (rstN),
  .decodeOut    (decodeOut),
  .decodeCredit (decodeCredit),
  .pop          (pop),
  .notEmpty     (notEmpty),
  .intTaken     (intTaken)
);

// File: bench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic gclk,
  output logic rstN
);

  initial begin
    gclk = 1'b0;
    forever #5 gclk = ~gclk;
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge gclk);
    #1;
    rstN = 1'b1;
  end

endmodule

// File: source/frontEnd.sv
`timescale 1ns/10ps

module frontEnd (
  input  logic                gclk,
  input  logic                rstN,
  input  linkPkg::fetchLinkT  fetchIn,
  output logic                fetchCredit,
  input  logic                intRequest,
  input  logic                intEnable,
  output linkPkg::decodeLinkT decodeOut,
  input  logic                decodeCredit
);

  logic [31:0] head;
  logic        notEmpty;
  logic        pop;
  logic        intPending;
  logic        intTaken;

  instQueue u_queue (
    .gclk        (gclk),
    .rstN        (rstN),
    .fetchIn     (fetchIn),
    .pop         (pop),
    .head        (head),
    .notEmpty    (notEmpty),
    .fetchCredit (fetchCredit)
  );

  // Runs free of the decode step so back-pressure never loses a request
  interruptLatch u_intLatch (
    .gclk       (gclk),
    .rstN       (rstN),
    .intRequest (intRequest),
    .intEnable  (intEnable),
    .intTaken   (intTaken),
    .intPending (intPending)
  );

  instDecode u_decode (
    .gclk         (gclk),
    .rstN         (rstN),
    .head         (head),
    .notEmpty     (notEmpty),
    .intPending   (intPending),
    .decodeCredit (decodeCredit),
    .pop          (pop),
    .intTaken     (intTaken),
    .decodeOut    (decodeOut)
  );

endmodule

// File: source/instDecode.sv
`timescale 1ns/10ps
`include "ibuf_params.svh"

module instDecode (
  input  logic                gclk,
  input  logic                rstN,
  input  logic [31:0]         head,
  input  logic                notEmpty,
  input  logic                intPending,
  input  logic                decodeCredit,
  output logic                pop,
  output logic                intTaken,
  output linkPkg::decodeLinkT decodeOut
);

  import isaPkg::*;

  localparam int unsigned OutCredits = `IBUF_OUT_CREDITS;
  localparam int unsigned CredW      = $clog2(OutCredits + 1);

  localparam instFieldsT IntFields = '{
    opcode: opcodeT'(`IBUF_INT_OPCODE),
    rd:     `IBUF_INT_RD,
    ra:     `IBUF_INT_RA,
    low:    `IBUF_INT_IMM
  };

  logic [CredW-1:0] outCredits;
  opcodeT           lastOpc;
  logic [15:0]      prefixHalf;
  logic             outValid;
  decodedOpT        outOp;
  logic             hasCredit;
  logic             takeInt;
  logic             takeWord;
  logic             step;
  logic             joinPrefix;
  instFieldsT       src;
  decodedOpT        nextOp;

  assign hasCredit = (outCredits != '0);

  // Interrupt goes first, but never into the slot after a prefix, return or branch
  assign takeInt  = hasCredit && intPending && !blocksInterrupt(lastOpc);
  assign takeWord = hasCredit && notEmpty && !takeInt;
  assign step     = takeInt || takeWord;
  assign pop      = takeWord;

  assign joinPrefix = (lastOpc == opImm);

  always_comb begin
    src = takeInt ? IntFields : instFieldsT'(head);

    nextOp.opcode = src.opcode;
    nextOp.rd     = src.rd;
    nextOp.ra     = src.ra;
    nextOp.rb     = src.low[15:11];
    // Upper half from the IMM prefix, else sign extension
    nextOp.imm         = joinPrefix ? {prefixHalf, src.low} : {{16{src.low[15]}}, src.low};
    nextOp.isInterrupt = takeInt;
  end

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      outCredits <= CredW'(OutCredits);
      lastOpc    <= opcodeT'(6'o00);
      outValid   <= 1'b0;
      intTaken   <= 1'b0;
    end else begin
      outValid <= step;
      // Lines up with the interrupt op on decodeOut
      intTaken <= takeInt;

      if (step) begin
        lastOpc <= nextOp.opcode;
      end

      if (step && !decodeCredit) begin
        outCredits <= outCredits - CredW'(1);
      end else if (!step && decodeCredit) begin
        outCredits <= outCredits + CredW'(1);
      end
    end
  end

  always_ff @(posedge gclk) begin
    if (step) begin
      outOp <= nextOp;
    end
    // Low half of every word, only read back after an IMM
    if (takeWord) begin
      prefixHalf <= src.low;
    end
  end

  assign decodeOut = '{valid: outValid, op: outOp};

endmodule

// File: source/interruptLatch.sv
`timescale 1ns/10ps

module interruptLatch (
  input  logic gclk,
  input  logic rstN,
  input  logic intRequest,
  input  logic intEnable,
  input  logic intTaken,
  output logic intPending
);

  logic [1:0] syncQ;
  logic       levelQ;
  logic       rise;

  // Edge of the synchronized level, not of the raw pin
  assign rise = syncQ[1] && !levelQ;

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      syncQ      <= '0;
      levelQ     <= 1'b0;
      intPending <= 1'b0;
    end else begin
      // Request only sampled while enabled, a masked pulse never enters
      if (intEnable) begin
        syncQ <= {syncQ[0], intRequest};
      end
      levelQ <= syncQ[1];

      // A new edge wins over a take in the same cycle
      intPending <= intEnable && ((intPending && !intTaken) || rise);
    end
  end

endmodule

// File: source/instQueue.sv
`timescale 1ns/10ps
`include "ibuf_params.svh"

module instQueue (
  input  logic               gclk,
  input  logic               rstN,
  input  linkPkg::fetchLinkT fetchIn,
  input  logic               pop,
  output logic [31:0]        head,
  output logic               notEmpty,
  output logic               fetchCredit
);

  localparam int unsigned Depth = `IBUF_QUEUE_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [31:0]     mem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            push;
  logic            doPop;

  // Sender holds a credit for every valid word, so a push never meets a full queue
  assign push  = fetchIn.valid;
  assign doPop = pop && notEmpty;

  assign head     = mem[rdPtr];
  assign notEmpty = (count != '0);

  always_ff @(posedge gclk) begin
    if (push) begin
      mem[wrPtr] <= fetchIn.word;
    end
  end

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      fetchCredit <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end

      case ({push, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase

      // Freed entry goes straight back to the sender
      fetchCredit <= doPop;
    end
  end

endmodule

// File: source/linkPkg.sv
package linkPkg;

  // Word from the fetch source, one credit per valid beat
  typedef struct packed {
    logic        valid;
    logic [31:0] word;
  } fetchLinkT;

  // Decoded operation toward the consumer, one credit per valid beat
  typedef struct packed {
    logic              valid;
    isaPkg::decodedOpT op;
  } decodeLinkT;

endpackage

// File: source/isaPkg.sv
package isaPkg;

  // Opcodes the front end cares about, all others pass through untouched
  typedef enum logic [5:0] {
    opBru  = 6'o46,
    opBcc  = 6'o47,
    opImm  = 6'o54,
    opRtd  = 6'o55,
    opBrui = 6'o56,
    opBcci = 6'o57
  } opcodeT;

  // Raw instruction word, rb sits in the top five bits of low
  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] low;
  } instFieldsT;

  typedef struct packed {
    opcodeT      opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] imm;
    logic        isInterrupt;
  } decodedOpT;

  // Prefix, return and branches all own the next slot
  function automatic logic blocksInterrupt(opcodeT opc);
    case (opc)
      opImm, opRtd, opBru, opBrui, opBcc, opBcci: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// File: source/ibuf_params.svh
`ifndef IBUF_PARAMS_SVH
`define IBUF_PARAMS_SVH

// Queue entries, also the fetch credits granted after reset
`define IBUF_QUEUE_DEPTH 4

// Decode output credits granted after reset
`define IBUF_OUT_CREDITS 2

// Fixed interrupt branch inserted into the stream
`define IBUF_INT_OPCODE 6'o56
`define IBUF_INT_RD 5'h1e
`define IBUF_INT_RA 5'h0c
`define IBUF_INT_IMM 16'h0060

`endif
